// File: common/dll_tx_settings.svh
// fixed widths and CRC constants for the transmit data link layer
// the bus is 32 bits wide, and other widths are not supported
`ifndef DLL_TX_SETTINGS_SVH
`define DLL_TX_SETTINGS_SVH

// stream width and byte enables
`define DLL_DATA_W 32
`define DLL_KEEP_W 4

// transmit sequence number, sent in a 16-bit field
`define DLL_SEQ_W 12

// header credit counters wrap modulo 256
`define DLL_CRED_W 8

// LCRC polynomial 04C11DB7, in reflected form
`define DLL_LCRC_POLY 32'hEDB88320

// LCRC start value
`define DLL_LCRC_INIT 32'hFFFFFFFF

`endif

// File: common/dll_tx_pkg.sv
// types shared by the transmit data link layer and its testbench
// widths come from the settings header
`include "dll_tx_settings.svh"

package dll_tx_pkg;

  typedef logic [`DLL_DATA_W-1:0] dword_t;
  typedef logic [`DLL_SEQ_W-1:0]  seq_num_t;
  typedef logic [`DLL_CRED_W-1:0] credit_t;
  typedef logic [31:0]            crc_t;

  // beat from the transaction layer, always a whole dword
  typedef struct packed {
    dword_t data;
    logic   last;
  } tlp_beat_t;

  // framed beat towards the physical layer
  typedef struct packed {
    dword_t                 data;
    logic [`DLL_KEEP_W-1:0] keep;
    logic                   last;
  } dllp_beat_t;

  // header credits, one field per class
  typedef struct packed {
    credit_t ph;
    credit_t nph;
    credit_t cplh;
  } fc_limits_t;

  typedef enum logic [1:0] {
    TLP_POSTED,
    TLP_NONPOSTED,
    TLP_CPL
  } tlp_class_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_STREAM,
    ST_CRC_LO,
    ST_CRC_HI,
    ST_DONE
  } framer_state_e;

endpackage

// File: logic/tlp_skid_buffer.sv
// two-entry register stage for a valid/ready stream
// in_ready_o comes from a flop, so the upstream ready path is cut
`timescale 1ns/1ps

module tlp_skid_buffer #(
  parameter type beat_t = dll_tx_pkg::tlp_beat_t
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  beat_t in_beat_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output beat_t out_beat_o,
  output logic  out_valid_o,
  input  logic  out_ready_i
);

  beat_t main_q;
  beat_t skid_q;
  logic  main_valid_q;
  logic  skid_valid_q;
  logic  main_load;

  // main register may take a new beat when empty or being drained
  assign main_load   = out_ready_i || !main_valid_q;
  assign in_ready_o  = !skid_valid_q;
  assign out_beat_o  = main_q;
  assign out_valid_o = main_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      main_valid_q <= skid_valid_q || in_valid_i;
      skid_valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      // downstream stalled, park the beat in the skid entry
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_q <= skid_valid_q ? skid_q : in_beat_i;
    end
    if (!main_load && in_ready_o) begin
      skid_q <= in_beat_i;
    end
  end

  // a stalled beat must not change before it is taken
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_beat_o))
  );

endmodule

// File: framer/lcrc32_dword.sv
// running reflected CRC-32 over 4 bytes, or the low 2 bytes with half_i
// clear_i together with update_i folds into a fresh start value
// crc_o is complemented and follows each update by one edge
`timescale 1ns/1ps
`include "dll_tx_settings.svh"

module lcrc32_dword (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               clear_i,
  input  logic               update_i,
  input  logic               half_i,
  input  dll_tx_pkg::dword_t bytes_i,
  output dll_tx_pkg::crc_t   crc_o
);

  import dll_tx_pkg::*;

  crc_t crc_q;
  crc_t crc_base;
  crc_t crc_next;

  // one byte, lowest bit first
  function automatic crc_t fold_byte(crc_t crc, logic [7:0] b);
    crc_t c;
    c = crc ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ `DLL_LCRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  always_comb begin
    crc_base = clear_i ? `DLL_LCRC_INIT : crc_q;
    crc_next = fold_byte(fold_byte(crc_base, bytes_i[7:0]), bytes_i[15:8]);
    if (!half_i) begin
      crc_next = fold_byte(fold_byte(crc_next, bytes_i[23:16]), bytes_i[31:24]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      crc_q <= `DLL_LCRC_INIT;
    end else if (update_i) begin
      crc_q <= crc_next;
    end else if (clear_i) begin
      crc_q <= `DLL_LCRC_INIT;
    end
  end

  assign crc_o = ~crc_q;

endmodule

// File: flow_control/fc_credit_gate.sv
// header credit gate for posted, non-posted and completion TLPs
// limits load on fc_update_i; one credit is consumed per finished TLP
// counters wrap modulo 256, headroom exists while consumed differs from limit
`timescale 1ns/1ps

module fc_credit_gate (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  dll_tx_pkg::fc_limits_t fc_limits_i,
  input  logic                   fc_update_i,
  input  dll_tx_pkg::tlp_class_e req_class_i,
  input  logic                   req_valid_i,
  output logic                   grant_o,
  input  logic                   consume_i
);

  import dll_tx_pkg::*;

  fc_limits_t limit_q;
  // consumed counts, same layout as the limits
  fc_limits_t used_q;
  credit_t    lim_sel;
  credit_t    used_sel;
  credit_t    headroom;
  logic       granted_q;
  tlp_class_e granted_cls_q;

  always_comb begin
    lim_sel  = '0;
    used_sel = '0;
    case (req_class_i)
      TLP_POSTED: begin
        lim_sel  = limit_q.ph;
        used_sel = used_q.ph;
      end
      TLP_NONPOSTED: begin
        lim_sel  = limit_q.nph;
        used_sel = used_q.nph;
      end
      TLP_CPL: begin
        lim_sel  = limit_q.cplh;
        used_sel = used_q.cplh;
      end
      default: begin
      end
    endcase
  end

  assign headroom = lim_sel - used_sel;
  assign grant_o  = req_valid_i && (headroom != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      limit_q <= '0;
      used_q  <= '0;
    end else begin
      if (fc_update_i) begin
        limit_q <= fc_limits_i;
      end
      if (consume_i) begin
        case (req_class_i)
          TLP_POSTED:    used_q.ph   <= used_q.ph + 1'b1;
          TLP_NONPOSTED: used_q.nph  <= used_q.nph + 1'b1;
          TLP_CPL:       used_q.cplh <= used_q.cplh + 1'b1;
          default: begin
          end
        endcase
      end
    end
  end

  // last grant handed out, open until the framer consumes it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      granted_q <= 1'b0;
    end else if (consume_i) begin
      granted_q <= 1'b0;
    end else if (grant_o) begin
      granted_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_o && !consume_i) begin
      granted_cls_q <= req_class_i;
    end
  end

  a_consume_granted: assert property (
    @(posedge clk_i) disable iff (rst_i)
    consume_i |-> (granted_q && granted_cls_q == req_class_i)
  );

  a_no_overrun: assert property (
    @(posedge clk_i) disable iff (rst_i)
    consume_i |-> (headroom != '0)
  );

endmodule

// File: framer/tlp_framer.sv
// frames TLPs as seq field + TLP shifted by 2 bytes + LCRC
// input dwords are always whole; the LCRC ends in a keep 0011 beat
// the sequence number advances in ST_DONE, one cycle after each packet
`timescale 1ns/1ps

module tlp_framer (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  dll_tx_pkg::tlp_beat_t  in_beat_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output dll_tx_pkg::dllp_beat_t out_beat_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output dll_tx_pkg::tlp_class_e req_class_o,
  output logic                   req_valid_o,
  input  logic                   grant_i,
  output logic                   consume_o,
  output dll_tx_pkg::seq_num_t   seq_num_o,
  output logic                   dllp_sent_o
);

  import dll_tx_pkg::*;

  framer_state_e state_q;
  framer_state_e state_c;
  seq_num_t      seq_q;
  seq_num_t      seq_inc;
  logic [15:0]   seq_field;
  logic [15:0]   seq_inc_field;
  logic [15:0]   prev_hi_q;
  tlp_class_e    class_q;
  tlp_class_e    class_dec;
  logic          in_xfer;
  logic          crc_clear;
  logic          crc_update;
  logic          crc_half;
  dword_t        crc_bytes;
  crc_t          lcrc;

  assign seq_inc       = seq_q + 1'b1;
  assign seq_field     = 16'(seq_q);
  assign seq_inc_field = 16'(seq_inc);
  assign seq_num_o     = seq_q;

  // class from the format/type byte of the head dword
  always_comb begin
    case (in_beat_i.data[7:0])
      8'h0A, 8'h4A: class_dec = TLP_CPL;
      8'h40, 8'h60: class_dec = TLP_POSTED;
      default:      class_dec = TLP_NONPOSTED;
    endcase
  end

  assign req_valid_o = (state_q == ST_IDLE) && in_valid_i;
  assign req_class_o = (state_q == ST_IDLE) ? class_dec : class_q;

  assign in_ready_o = out_ready_i &&
                      (((state_q == ST_IDLE) && grant_i) || (state_q == ST_STREAM));
  assign in_xfer    = in_valid_i && in_ready_o;

  always_comb begin
    state_c         = state_q;
    out_valid_o     = 1'b0;
    out_beat_o      = '0;
    out_beat_o.keep = '1;
    crc_clear       = 1'b0;
    crc_update      = 1'b0;
    crc_half        = 1'b0;
    crc_bytes       = in_beat_i.data;
    consume_o       = 1'b0;
    dllp_sent_o     = 1'b0;
    case (state_q)
      ST_IDLE: begin
        out_valid_o     = in_valid_i && grant_i;
        out_beat_o.data = {in_beat_i.data[15:0], seq_field};
        // until the head is taken keep the CRC at start value + seq bytes
        crc_update = 1'b1;
        crc_clear  = !in_xfer;
        crc_half   = !in_xfer;
        if (!in_xfer) begin
          crc_bytes = {16'h0, seq_field};
        end else begin
          state_c = in_beat_i.last ? ST_CRC_LO : ST_STREAM;
        end
      end
      ST_STREAM: begin
        out_valid_o     = in_valid_i;
        out_beat_o.data = {in_beat_i.data[15:0], prev_hi_q};
        crc_update      = in_xfer;
        if (in_xfer && in_beat_i.last) begin
          state_c = ST_CRC_LO;
        end
      end
      ST_CRC_LO: begin
        out_valid_o     = 1'b1;
        out_beat_o.data = {lcrc[15:0], prev_hi_q};
        if (out_ready_i) begin
          state_c = ST_CRC_HI;
        end
      end
      ST_CRC_HI: begin
        out_valid_o     = 1'b1;
        out_beat_o.data = {16'h0, lcrc[31:16]};
        out_beat_o.keep = 4'b0011;
        out_beat_o.last = 1'b1;
        if (out_ready_i) begin
          consume_o   = 1'b1;
          dllp_sent_o = 1'b1;
          state_c     = ST_DONE;
        end
      end
      ST_DONE: begin
        // start the next packet's CRC with its sequence bytes
        crc_clear  = 1'b1;
        crc_update = 1'b1;
        crc_half   = 1'b1;
        crc_bytes  = {16'h0, seq_inc_field};
        state_c    = ST_IDLE;
      end
      default: begin
        state_c = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      seq_q   <= '0;
    end else begin
      state_q <= state_c;
      if (state_q == ST_DONE) begin
        seq_q <= seq_inc;
      end
    end
  end

  // upper half of each dword goes out with the next beat
  always_ff @(posedge clk_i) begin
    if (in_xfer) begin
      prev_hi_q <= in_beat_i.data[31:16];
    end
    if (in_xfer && state_q == ST_IDLE) begin
      class_q <= class_dec;
    end
  end

  lcrc32_dword lcrc_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .clear_i  (crc_clear),
    .update_i (crc_update),
    .half_i   (crc_half),
    .bytes_i  (crc_bytes),
    .crc_o    (lcrc)
  );

  // no packet starts while the credit gate withholds a grant
  a_idle_needs_grant: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ((state_q == ST_IDLE) && !grant_i) |=> (state_q == ST_IDLE)
  );

endmodule

// File: logic/dll_tx_top.sv
// transmit data link layer: input buffer, framer, credit gate, output buffer
// no TLP is sent until the first credit update after reset
`timescale 1ns/1ps

module dll_tx_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  dll_tx_pkg::tlp_beat_t  s_beat_i,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,
  output dll_tx_pkg::dllp_beat_t m_beat_o,
  output logic                   m_valid_o,
  input  logic                   m_ready_i,
  input  dll_tx_pkg::fc_limits_t fc_limits_i,
  input  logic                   fc_update_i,
  output dll_tx_pkg::seq_num_t   seq_num_o,
  output logic                   dllp_sent_o
);

  import dll_tx_pkg::*;

  // buffered TLP stream into the framer
  tlp_beat_t  head_beat;
  logic       head_valid;
  logic       head_ready;
  // framed stream into the output buffer
  dllp_beat_t frm_beat;
  logic       frm_valid;
  logic       frm_ready;
  tlp_class_e req_class;
  logic       req_valid;
  logic       grant;
  logic       consume;

  tlp_skid_buffer in_buf_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_beat_i   (s_beat_i),
    .in_valid_i  (s_valid_i),
    .in_ready_o  (s_ready_o),
    .out_beat_o  (head_beat),
    .out_valid_o (head_valid),
    .out_ready_i (head_ready)
  );

  tlp_framer framer_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_beat_i   (head_beat),
    .in_valid_i  (head_valid),
    .in_ready_o  (head_ready),
    .out_beat_o  (frm_beat),
    .out_valid_o (frm_valid),
    .out_ready_i (frm_ready),
    .req_class_o (req_class),
    .req_valid_o (req_valid),
    .grant_i     (grant),
    .consume_o   (consume),
    .seq_num_o   (seq_num_o),
    .dllp_sent_o (dllp_sent_o)
  );

  fc_credit_gate credit_gate_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fc_limits_i (fc_limits_i),
    .fc_update_i (fc_update_i),
    .req_class_i (req_class),
    .req_valid_i (req_valid),
    .grant_o     (grant),
    .consume_i   (consume)
  );

  tlp_skid_buffer #(
    .beat_t (dllp_beat_t)
  ) out_buf_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_beat_i   (frm_beat),
    .in_valid_i  (frm_valid),
    .in_ready_o  (frm_ready),
    .out_beat_o  (m_beat_o),
    .out_valid_o (m_valid_o),
    .out_ready_i (m_ready_i)
  );

endmodule

// File: sim/dll_tx_tb_model.svh
// reference model for the transmit testbench, included inside the testbench module
// needs dll_tx_pkg imported before the include
// bodies are whole dwords and byte 0 of the first dword selects the class
`ifndef DLL_TX_TB_MODEL_SVH
`define DLL_TX_TB_MODEL_SVH

// 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] st);
  return st * 32'd1103515245 + 32'd12345;
endfunction

// TLP body of n dwords, format/type byte placed in byte 0
function automatic void gen_body(input logic [7:0] fmt, input int n,
                                 ref logic [31:0] st, ref dword_t body[$]);
  dword_t d;
  body.delete();
  for (int k = 0; k < n; k++) begin
    st = lcg_next(st);
    d[31:16] = st[31:16];
    st = lcg_next(st);
    d[15:0] = st[31:16];
    if (k == 0) begin
      d[7:0] = fmt;
    end
    body.push_back(d);
  end
endfunction

// bit-serial reflected CRC-32 over a byte stream, lowest bit of each byte first
function automatic crc_t lcrc_of(input logic [7:0] bytes[$]);
  crc_t crc;
  logic fb;
  crc = `DLL_LCRC_INIT;
  foreach (bytes[i]) begin
    for (int b = 0; b < 8; b++) begin
      fb  = crc[0] ^ bytes[i][b];
      crc = crc >> 1;
      if (fb) begin
        crc = crc ^ `DLL_LCRC_POLY;
      end
    end
  end
  return ~crc;
endfunction

function automatic dllp_beat_t make_beat(input dword_t d, input logic [3:0] k, input logic l);
  dllp_beat_t b;
  b.data = d;
  b.keep = k;
  b.last = l;
  return b;
endfunction

// seq field, body shifted by 2 bytes, then the LCRC halves
function automatic void build_frame(input seq_num_t seq, input dword_t body[$],
                                    ref dllp_beat_t beats[$]);
  logic [7:0]  stream[$];
  logic [15:0] seq16;
  crc_t        crc;
  int          n;
  n     = body.size();
  seq16 = 16'(seq);
  beats.delete();
  stream.push_back(seq16[7:0]);
  stream.push_back(seq16[15:8]);
  foreach (body[i]) begin
    for (int b = 0; b < 4; b++) begin
      stream.push_back(body[i][8*b +: 8]);
    end
  end
  crc = lcrc_of(stream);
  beats.push_back(make_beat({body[0][15:0], seq16}, 4'b1111, 1'b0));
  for (int k = 1; k < n; k++) begin
    beats.push_back(make_beat({body[k][15:0], body[k-1][31:16]}, 4'b1111, 1'b0));
  end
  beats.push_back(make_beat({crc[15:0], body[n-1][31:16]}, 4'b1111, 1'b0));
  beats.push_back(make_beat({16'h0, crc[31:16]}, 4'b0011, 1'b1));
endfunction

// only bytes with keep set carry meaning
function automatic bit beat_ok(input dllp_beat_t exp, input dllp_beat_t act);
  bit ok;
  ok = (exp.keep == act.keep) && (exp.last == act.last);
  for (int i = 0; i < `DLL_KEEP_W; i++) begin
    if (exp.keep[i] && (exp.data[8*i +: 8] != act.data[8*i +: 8])) begin
      ok = 1'b0;
    end
  end
  return ok;
endfunction

`endif

// File: sim/dll_tx_tb.sv
// testbench for dll_tx_top, TLPs from a table, one packet in flight at a time
// inputs change on the falling edge, outputs are sampled 1 ns after it
// back-pressure entries toggle m_ready_i from an LCG
`timescale 1ns/1ps
`include "dll_tx_settings.svh"

module dll_tx_tb;

  import dll_tx_pkg::*;

  `include "dll_tx_tb_model.svh"

  localparam int CLK_HALF       = 2;
  localparam int HOLD_CYCLES    = 24;
  localparam int UPD_NONE       = 0;
  localparam int UPD_BEFORE     = 1;
  localparam int UPD_AFTER_HOLD = 2;

  typedef struct {
    string      name;
    logic [7:0] fmt;
    int         len;
    fc_limits_t lim;
    int         upd;
    bit         bp;
  } entry_t;

  logic       clk_i;
  logic       rst_i;
  tlp_beat_t  s_beat_i;
  logic       s_valid_i;
  logic       s_ready_o;
  dllp_beat_t m_beat_o;
  logic       m_valid_o;
  logic       m_ready_i;
  fc_limits_t fc_limits_i;
  logic       fc_update_i;
  seq_num_t   seq_num_o;
  logic       dllp_sent_o;

  entry_t      tbl[$];
  dllp_beat_t  exp_q[$];
  string       cur_name;
  logic [31:0] body_st = 32'd58388;
  logic [31:0] rdy_st  = 32'd58388;
  bit          bp_on   = 1'b0;
  int          errors      = 0;
  int          beat_count  = 0;
  int          beat_in_pkt = 0;
  int          pkt_count   = 0;
  int          sent_count  = 0;
  int          cycles      = 0;
  int          cycle_limit = 200;

  dll_tx_top dll_tx_top_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s_beat_i    (s_beat_i),
    .s_valid_i   (s_valid_i),
    .s_ready_o   (s_ready_o),
    .m_beat_o    (m_beat_o),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .fc_limits_i (fc_limits_i),
    .fc_update_i (fc_update_i),
    .seq_num_o   (seq_num_o),
    .dllp_sent_o (dllp_sent_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("error: timeout after %0d cycles in %s", cycles, cur_name);
      $display("Test failed");
      $finish;
    end
  end

  // random ready only while a back-pressure entry runs
  always @(negedge clk_i) begin
    if (bp_on) begin
      rdy_st    = lcg_next(rdy_st);
      m_ready_i = rdy_st[20];
    end else begin
      m_ready_i = 1'b1;
    end
  end

  task automatic check_beat();
    dllp_beat_t exp;
    beat_count++;
    if (exp_q.size() == 0) begin
      errors++;
      $display("error: unexpected output beat %h in %s", m_beat_o, cur_name);
    end else begin
      exp = exp_q.pop_front();
      if (!beat_ok(exp, m_beat_o)) begin
        errors++;
        $display("mismatch %s beat %0d: expected %h actual %h",
                 cur_name, beat_in_pkt, exp, m_beat_o);
      end
    end
    beat_in_pkt++;
    if (m_beat_o.last) begin
      pkt_count++;
      beat_in_pkt = 0;
    end
  endtask

  // the handshake seen here completes on the next rising edge
  always @(negedge clk_i) begin
    #1;
    if (!rst_i) begin
      if (dllp_sent_o) begin
        sent_count++;
      end
      if (m_valid_o && m_ready_i) begin
        check_beat();
      end
    end
  end

  function automatic void add_entry(input string name, input logic [7:0] fmt, input int len,
                                    input credit_t ph, input credit_t nph, input credit_t cplh,
                                    input int upd, input bit bp);
    entry_t e;
    e.name     = name;
    e.fmt      = fmt;
    e.len      = len;
    e.lim.ph   = ph;
    e.lim.nph  = nph;
    e.lim.cplh = cplh;
    e.upd      = upd;
    e.bp       = bp;
    tbl.push_back(e);
  endfunction

  function automatic void build_table();
    add_entry("np_zero_credit", 8'h00, 3, 8'd0, 8'd1, 8'd0, UPD_AFTER_HOLD, 1'b0);
    // posted credit runs out after these eight
    for (int n = 1; n <= 8; n++) begin
      add_entry($sformatf("posted_len%0d", n), (n % 2 == 1) ? 8'h40 : 8'h60, n,
                8'd8, 8'd1, 8'd0, (n == 1) ? UPD_BEFORE : UPD_NONE, 1'b0);
    end
    add_entry("cpl_own_credit", 8'h4A, 3, 8'd8, 8'd1, 8'd2, UPD_BEFORE, 1'b0);
    add_entry("posted_over_limit", 8'h40, 4, 8'd9, 8'd1, 8'd2, UPD_AFTER_HOLD, 1'b0);
    add_entry("cpl_second", 8'h0A, 2, 8'd9, 8'd1, 8'd2, UPD_NONE, 1'b0);
    add_entry("bp_posted", 8'h60, 5, 8'd20, 8'd10, 8'd10, UPD_BEFORE, 1'b1);
    add_entry("bp_nonposted", 8'h20, 7, 8'd20, 8'd10, 8'd10, UPD_NONE, 1'b1);
    add_entry("bp_cpl", 8'h4A, 1, 8'd20, 8'd10, 8'd10, UPD_NONE, 1'b1);
    add_entry("bp_posted_long", 8'h40, 8, 8'd20, 8'd10, 8'd10, UPD_NONE, 1'b1);
  endfunction

  task automatic apply_limits(input fc_limits_t lim);
    @(negedge clk_i);
    fc_limits_i = lim;
    fc_update_i = 1'b1;
    @(negedge clk_i);
    fc_update_i = 1'b0;
  endtask

  task automatic send_tlp(input dword_t body[$]);
    foreach (body[i]) begin
      @(negedge clk_i);
      s_beat_i.data = body[i];
      s_beat_i.last = (i == body.size() - 1);
      s_valid_i     = 1'b1;
      #1;
      while (!s_ready_o) begin
        @(negedge clk_i);
        #1;
      end
    end
    @(negedge clk_i);
    s_valid_i = 1'b0;
  endtask

  // nothing may leave while the credit is missing
  task automatic hold_then_update(input entry_t e);
    repeat (HOLD_CYCLES) begin
      @(negedge clk_i);
      #1;
      if (m_valid_o) begin
        errors++;
        $display("error: %s sent an output beat before its credit was granted", e.name);
      end
    end
    apply_limits(e.lim);
  endtask

  task automatic run_entry(input entry_t e, input int idx);
    dword_t     body[$];
    dllp_beat_t beats[$];
    cur_name = e.name;
    bp_on   <= e.bp;
    gen_body(e.fmt, e.len, body_st, body);
    build_frame(seq_num_t'(idx), body, beats);
    foreach (beats[k]) begin
      exp_q.push_back(beats[k]);
    end
    if (e.upd == UPD_BEFORE) begin
      apply_limits(e.lim);
    end
    if (e.upd == UPD_AFTER_HOLD) begin
      fork
        send_tlp(body);
        hold_then_update(e);
      join
    end else begin
      send_tlp(body);
    end
    while (pkt_count < idx + 1) begin
      @(negedge clk_i);
    end
    // the sequence counter steps one cycle after the last beat leaves the framer
    @(negedge clk_i);
    if (seq_num_o != seq_num_t'(idx + 1)) begin
      errors++;
      $display("mismatch %s seq_num_o: expected %0d actual %0d", e.name, idx + 1, seq_num_o);
    end
    if (sent_count != idx + 1) begin
      errors++;
      $display("mismatch %s dllp_sent_o pulses: expected %0d actual %0d",
               e.name, idx + 1, sent_count);
    end
  endtask

  initial begin
    int total_dw;
    rst_i       = 1'b1;
    s_beat_i    = '0;
    s_valid_i   = 1'b0;
    m_ready_i   = 1'b1;
    fc_limits_i = '0;
    fc_update_i = 1'b0;
    cur_name    = "reset";
    build_table();
    total_dw = 0;
    foreach (tbl[i]) begin
      total_dw += tbl[i].len;
    end
    cycle_limit = total_dw * 40 + 200;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    foreach (tbl[i]) begin
      run_entry(tbl[i], i);
    end
    repeat (10) @(negedge clk_i);
    if (exp_q.size() != 0) begin
      errors++;
      $display("error: %0d expected beats never appeared", exp_q.size());
    end
    $display("errors=%0d beats=%0d packets=%0d", errors, beat_count, pkt_count);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+common
+incdir+sim
common/dll_tx_pkg.sv
logic/tlp_skid_buffer.sv
framer/lcrc32_dword.sv
flow_control/fc_credit_gate.sv
framer/tlp_framer.sv
logic/dll_tx_top.sv
sim/dll_tx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the testbench with Verilator, run it and scan the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dll_tx_tb_sim

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module dll_tx_tb \
  -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Test passed" "$LOG"; then
  echo "no result line found in $LOG"
  exit 1
fi

exit 0
